//--- drive_hold.sv
`timescale 1ns/100ps
`default_nettype none

// Holds the slow drive pair and replays it at the stream rate
module drive_hold
	import fdbk_sample_pkg::*;
(
	input  wire          clk,
	input  wire          rst_n,
	input  wire sample_t drv_i,
	input  wire sample_t drv_q,
	input  wire          drv_valid,
	input  wire          iq,
	output sample_t      hold_xy
);

	sample_t lat_i;
	sample_t lat_q;
	sample_t cur_i;
	sample_t cur_q;

	// New pair bypasses the latch so it shows on the very next cycle
	assign cur_i = drv_valid ? drv_i : lat_i;
	assign cur_q = drv_valid ? drv_q : lat_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lat_i <= '0;
			lat_q <= '0;
			hold_xy <= '0;
		end else begin
			if (drv_valid) begin
				lat_i <= drv_i;
				lat_q <= drv_q;
			end
			// I when iq is high, Q otherwise
			hold_xy <= iq ? cur_i : cur_q;
		end
	end

endmodule

`default_nettype wire

//--- fdbk_core.sv
`timescale 1ns/100ps
`default_nettype none

// Feedback controller core, Cartesian slow path plus low-latency path
module fdbk_core
	import fdbk_sample_pkg::*, fdbk_ctrl_pkg::*;
#(
	parameter int GAIN_SHIFT = 12,
	parameter int INT_SHIFT = 4
)(
	input  wire          clk,
	input  wire          rst_n,
	// Interleaved stream, iq high on I, sync on the first I of a frame
	input  wire sample_t in_xy,
	input  wire          iq,
	input  wire          sync,
	// Static settings
	input  wire sample_t set_i,
	input  wire sample_t set_q,
	input  wire gain_t   kp,
	input  wire gain_t   ki,
	input  wire sample_t lim_hi,
	input  wire sample_t lim_lo,
	input  wire cshift_t coarse_scale,
	input  wire          ll_en,
	output sample_t      out_xy
);

	// Decimator outputs
	sample_t avg_i;
	sample_t avg_q;
	logic avg_valid;

	// Controller outputs
	sample_t drv_i;
	sample_t drv_q;
	logic drv_valid;

	// Stream-rate drives
	sample_t hold_xy;
	sample_t prop_xy;

	// Frame averages, valid the cycle after the last Q
	iq_decim4 iq_decim4_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_xy     (in_xy),
		.iq        (iq),
		.sync      (sync),
		.avg_i     (avg_i),
		.avg_q     (avg_q),
		.avg_valid (avg_valid)
	);

	// Two-stage PI with clamp
	iq_pi_ctrl #(
		.GAIN_SHIFT (GAIN_SHIFT),
		.INT_SHIFT  (INT_SHIFT)
	) iq_pi_ctrl_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.avg_i     (avg_i),
		.avg_q     (avg_q),
		.avg_valid (avg_valid),
		.set_i     (set_i),
		.set_q     (set_q),
		.lim_hi    (lim_hi),
		.lim_lo    (lim_lo),
		.kp        (kp),
		.ki        (ki),
		.drv_i     (drv_i),
		.drv_q     (drv_q),
		.drv_valid (drv_valid)
	);

	// Slow drive replayed on the stream slots
	drive_hold drive_hold_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.drv_i     (drv_i),
		.drv_q     (drv_q),
		.drv_valid (drv_valid),
		.iq        (iq),
		.hold_xy   (hold_xy)
	);

	// Fast correction on top of the held drive
	ll_prop ll_prop_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_xy        (in_xy),
		.hold_xy      (hold_xy),
		.set_i        (set_i),
		.set_q        (set_q),
		.iq           (iq),
		.coarse_scale (coarse_scale),
		.prop_xy      (prop_xy)
	);

	// Output path select
	assign out_xy = ll_en ? prop_xy : hold_xy;

endmodule

`default_nettype wire

//--- fdbk_ctrl_pkg.sv
`default_nettype none

// Controller settings and the decimator frame state
package fdbk_ctrl_pkg;

	localparam int GAIN_W = 16;
	localparam int CSHIFT_W = 2;

	// Fixed part of the low-latency shift, the coarse code adds twice its value
	localparam int LL_BASE_SHIFT = 4;

	// Unsigned proportional or integral gain
	typedef logic [GAIN_W-1:0] gain_t;

	// Coarse scale code of the low-latency path
	typedef logic [CSHIFT_W-1:0] cshift_t;

	// Position inside the eight-word frame, I and Q interleaved
	typedef enum logic [2:0] {
		PH_I0, PH_Q0,
		PH_I1, PH_Q1,
		PH_I2, PH_Q2,
		PH_I3, PH_Q3
	} decim_phase_t;

endpackage

`default_nettype wire

//--- fdbk_sample_pkg.sv
`default_nettype none

// Widths and types of the stream samples and the arithmetic built on them
package fdbk_sample_pkg;

	// One interleaved stream word, also the width of a drive word
	localparam int SAMPLE_W = 18;

	// Four samples summed need two more bits, one spare for headroom
	localparam int SUM_W = SAMPLE_W + 3;

	// Full product of an error and a gain
	localparam int WIDE_W = 2 * SAMPLE_W;

	// Signed stream sample or drive word
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Difference of two samples, one bit wider so it never wraps
	typedef logic signed [SAMPLE_W:0] err_t;

	// Sum of the four samples of one component in a frame
	typedef logic signed [SUM_W-1:0] sum_t;

	// Gain product and integrator accumulator
	typedef logic signed [WIDE_W-1:0] wide_t;

	// Saturation bounds of a drive word
	localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

endpackage

`default_nettype wire

//--- iq_decim4.sv
`timescale 1ns/100ps
`default_nettype none

// Decimate by four, averaging the four I/Q pairs of each frame
module iq_decim4
	import fdbk_sample_pkg::*, fdbk_ctrl_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	input  wire sample_t in_xy,
	input  wire         iq,
	input  wire         sync,
	output sample_t     avg_i,
	output sample_t     avg_q,
	output logic        avg_valid
);

	decim_phase_t phase;
	logic run;
	logic start;
	sum_t acc_i;
	sum_t acc_q;
	sum_t acc_q_fin;
	sum_t in_ext;

	// Sync only counts when it sits on an I word
	assign start = sync & iq;
	assign in_ext = sum_t'(in_xy);

	// Last Q word joins the sum on the same edge the average is taken
	assign acc_q_fin = acc_q + in_ext;

	// Frame position and the output strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_I0;
			run <= 1'b0;
			avg_valid <= 1'b0;
		end else begin
			avg_valid <= 1'b0;
			if (start) begin
				// Sync word is I0, so the next word is Q0
				phase <= PH_Q0;
				run <= 1'b1;
			end else if (run) begin
				avg_valid <= (phase == PH_Q3);
				phase <= (phase == PH_Q3) ? PH_I0 : decim_phase_t'(phase + 3'd1);
			end
		end
	end

	// Accumulators, a sync mid-frame drops the partial sums
	always_ff @(posedge clk) begin
		if (start) begin
			acc_i <= in_ext;
			acc_q <= '0;
		end else if (run) begin
			case (phase)
				// Free-running frame start when no sync arrives
				PH_I0: acc_i <= in_ext;
				PH_Q0: acc_q <= in_ext;
				PH_I1, PH_I2, PH_I3: acc_i <= acc_i + in_ext;
				PH_Q1, PH_Q2: acc_q <= acc_q + in_ext;
				PH_Q3: begin
					// Divide by four, rounding toward minus infinity
					avg_i <= sample_t'(acc_i >>> 2);
					avg_q <= sample_t'(acc_q_fin >>> 2);
				end
				default: acc_q <= acc_q;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- iq_pi_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// Cartesian PI controller, one lane each for I and Q
module iq_pi_ctrl
	import fdbk_sample_pkg::*, fdbk_ctrl_pkg::*;
#(
	parameter int GAIN_SHIFT = 12,
	parameter int INT_SHIFT = 4
)(
	input  wire          clk,
	input  wire          rst_n,
	input  wire sample_t avg_i,
	input  wire sample_t avg_q,
	input  wire          avg_valid,
	input  wire sample_t set_i,
	input  wire sample_t set_q,
	input  wire sample_t lim_hi,
	input  wire sample_t lim_lo,
	input  wire gain_t   kp,
	input  wire gain_t   ki,
	output sample_t      drv_i,
	output sample_t      drv_q,
	output logic         drv_valid
);

	// Integral increment sees the extra shift on top of the gain shift
	localparam int I_SHIFT = GAIN_SHIFT + INT_SHIFT;

	// Lane 0 is I, lane 1 is Q
	sample_t avg_v [2];
	sample_t set_v [2];
	err_t err [2];

	// Gains made signed with a zero sign bit
	logic signed [GAIN_W:0] kp_s;
	logic signed [GAIN_W:0] ki_s;

	// Stage one products
	wide_t prod_p [2];
	wide_t prod_i [2];
	logic v1;

	// Stage two state and arithmetic
	wide_t integ [2];
	wide_t int_cand [2];
	wide_t drv_sum [2];
	logic clip_hi [2];
	logic clip_lo [2];
	sample_t drv [2];

	assign avg_v[0] = avg_i;
	assign avg_v[1] = avg_q;
	assign set_v[0] = set_i;
	assign set_v[1] = set_q;
	assign kp_s = {1'b0, kp};
	assign ki_s = {1'b0, ki};

	// Error is setpoint minus average
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			err[k] = err_t'(set_v[k]) - err_t'(avg_v[k]);
		end
	end

	// Candidate integrator and drive before the clamp
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			int_cand[k] = integ[k] + (prod_i[k] >>> I_SHIFT);
			drv_sum[k] = int_cand[k] + (prod_p[k] >>> GAIN_SHIFT);
			clip_hi[k] = drv_sum[k] > wide_t'(lim_hi);
			clip_lo[k] = drv_sum[k] < wide_t'(lim_lo);
		end
	end

	// Strobes and integrators
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			drv_valid <= 1'b0;
			for (int k = 0; k < 2; k++) begin
				integ[k] <= '0;
			end
		end else begin
			v1 <= avg_valid;
			drv_valid <= v1;
			if (v1) begin
				for (int k = 0; k < 2; k++) begin
					// Anti-windup, the integrator holds while the drive clamps
					if (!clip_hi[k] && !clip_lo[k]) begin
						integ[k] <= int_cand[k];
					end
				end
			end
		end
	end

	// Products on the average strobe, clamped drive one cycle later
	always_ff @(posedge clk) begin
		if (avg_valid) begin
			for (int k = 0; k < 2; k++) begin
				prod_p[k] <= err[k] * kp_s;
				prod_i[k] <= err[k] * ki_s;
			end
		end
		if (v1) begin
			for (int k = 0; k < 2; k++) begin
				if (clip_hi[k]) begin
					drv[k] <= lim_hi;
				end else if (clip_lo[k]) begin
					drv[k] <= lim_lo;
				end else begin
					drv[k] <= sample_t'(drv_sum[k]);
				end
			end
		end
	end

	assign drv_i = drv[0];
	assign drv_q = drv[1];

endmodule

`default_nettype wire

//--- ll_prop.sv
`timescale 1ns/100ps
`default_nettype none

// Low-latency proportional path on every stream sample
module ll_prop
	import fdbk_sample_pkg::*, fdbk_ctrl_pkg::*;
(
	input  wire          clk,
	input  wire          rst_n,
	input  wire sample_t in_xy,
	input  wire sample_t hold_xy,
	input  wire sample_t set_i,
	input  wire sample_t set_q,
	input  wire          iq,
	input  wire cshift_t coarse_scale,
	output sample_t      prop_xy
);

	sample_t set_sel;
	err_t err;
	err_t err_sh;
	logic [3:0] shift;
	logic signed [SAMPLE_W+1:0] sum;

	// Setpoint for the component on the stream now
	assign set_sel = iq ? set_i : set_q;
	assign err = err_t'(set_sel) - err_t'(in_xy);

	// Shift runs from 4 to 10 in steps of two
	assign shift = 4'(LL_BASE_SHIFT) + {1'b0, coarse_scale, 1'b0};

	// hold_xy is one cycle behind iq, so it meets the registered error
	assign sum = hold_xy + err_sh;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			err_sh <= '0;
			prop_xy <= '0;
		end else begin
			err_sh <= err >>> shift;
			// Saturate back to a drive word
			if (sum > SAMPLE_MAX) begin
				prop_xy <= SAMPLE_MAX;
			end else if (sum < SAMPLE_MIN) begin
				prop_xy <= SAMPLE_MIN;
			end else begin
				prop_xy <= sample_t'(sum);
			end
		end
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
fdbk_sample_pkg.sv
fdbk_ctrl_pkg.sv
iq_decim4.sv
iq_pi_ctrl.sv
drive_hold.sv
ll_prop.sv
fdbk_core.sv
tb_fdbk_core.sv

//--- fdbk_tb_model.svh
`ifndef FDBK_TB_MODEL_SVH
`define FDBK_TB_MODEL_SVH

// Controller shifts, same as the DUT defaults
localparam int MODEL_GAIN_SHIFT = 12;
localparam int MODEL_INT_SHIFT = 4;
localparam longint MODEL_MAX = 131071;
localparam longint MODEL_MIN = -131072;
localparam int NUM_ROWS = 12;

typedef struct packed {
	int in_i;
	int in_q;
	int set_i;
	int set_q;
	int kp;
	int ki;
	int lim_hi;
	int lim_lo;
	int cscale;
	bit ll_en;
	bit noise;
	bit resync;
	int frames;
} stim_row_t;

stim_row_t stim_rows [NUM_ROWS];

// Words of the frame on the stream now
longint words [8];

// Model state, integrators and held drives
longint integ_i = 0;
longint integ_q = 0;
longint drv_i_m = 0;
longint drv_q_m = 0;
longint prev_q = 0;
int pend_row = 0;

task automatic fill_table();
	// in_i, in_q, set_i, set_q, kp, ki, lim_hi, lim_lo, cscale, ll_en, noise, resync, frames
	stim_rows[0] = '{1000, -500, 5000, 3000, 8192, 0, 60000, -60000, 0, 0, 0, 0, 3};
	stim_rows[1] = '{200, -300, 1200, 700, 4096, 0, 60000, -60000, 0, 0, 1, 0, 3};
	stim_rows[2] = '{0, 0, 50000, -50000, 8192, 0, 30000, -30000, 0, 0, 0, 0, 2};
	stim_rows[3] = '{1000, 1000, 3000, -1000, 2048, 32768, 20000, -20000, 0, 0, 0, 0, 6};
	stim_rows[4] = '{-10000, 10000, 3000, -3000, 2048, 32768, 20000, -20000, 0, 0, 0, 1, 4};
	stim_rows[5] = '{1000, 1000, 500, 1500, 2048, 32768, 20000, -20000, 0, 0, 0, 0, 4};
	stim_rows[6] = '{1000, 2000, 9000, -6000, 4096, 0, 60000, -60000, 0, 1, 0, 0, 2};
	stim_rows[7] = '{1000, 2000, 9000, -6000, 4096, 0, 60000, -60000, 1, 1, 0, 0, 2};
	stim_rows[8] = '{1000, 2000, 9000, -6000, 4096, 0, 60000, -60000, 2, 1, 0, 0, 2};
	stim_rows[9] = '{1000, 2000, 9000, -6000, 4096, 0, 60000, -60000, 3, 1, 0, 0, 2};
	// Full-scale drive plus a large fast error, both paths saturate
	stim_rows[10] = '{-100000, 100000, 100000, -100000, 4096, 0, 131071, -131072, 0, 1, 0, 0, 2};
	stim_rows[11] = '{0, 0, 2000, -2000, 4096, 16384, 50000, -50000, 0, 0, 0, 0, 3};
endtask

function automatic longint sat_word(input longint v);
	if (v > MODEL_MAX) begin
		return MODEL_MAX;
	end
	if (v < MODEL_MIN) begin
		return MODEL_MIN;
	end
	return v;
endfunction

// One PI lane, integrator frozen while the drive clamps
task automatic pi_lane(input longint set, input longint avg, input stim_row_t r,
		inout longint integ, inout longint drv);
	longint err;
	longint cand;
	longint total;
	err = set - avg;
	cand = integ + ((err * r.ki) >>> (MODEL_GAIN_SHIFT + MODEL_INT_SHIFT));
	total = cand + ((err * r.kp) >>> MODEL_GAIN_SHIFT);
	if (total > r.lim_hi) begin
		drv = r.lim_hi;
	end else if (total < r.lim_lo) begin
		drv = r.lim_lo;
	end else begin
		drv = total;
		integ = cand;
	end
endtask

// Frame average rounds toward minus infinity
task automatic model_frame(input int r);
	longint sum_i;
	longint sum_q;
	sum_i = words[0] + words[2] + words[4] + words[6];
	sum_q = words[1] + words[3] + words[5] + words[7];
	prev_q = drv_q_m;
	pi_lane(stim_rows[r].set_i, sum_i >>> 2, stim_rows[r], integ_i, drv_i_m);
	pi_lane(stim_rows[r].set_q, sum_q >>> 2, stim_rows[r], integ_q, drv_q_m);
endtask

// Fast path, base shift of 4 plus twice the coarse code
function automatic longint ll_sum(input longint drv, input longint set,
		input longint word, input int cs);
	return sat_word(drv + ((set - word) >>> (4 + 2 * cs)));
endfunction

// Fast path lags a cycle, so its first sample is still the old Q slot
function automatic longint expect_first();
	stim_row_t r;
	r = stim_rows[pend_row];
	if (r.ll_en) begin
		return ll_sum(prev_q, r.set_q, words[1], r.cscale);
	end
	return drv_i_m;
endfunction

function automatic longint expect_second();
	stim_row_t r;
	r = stim_rows[pend_row];
	if (r.ll_en) begin
		return ll_sum(drv_i_m, r.set_i, words[2], r.cscale);
	end
	return drv_q_m;
endfunction

`endif

//--- tb_fdbk_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fdbk_core
	import fdbk_sample_pkg::*, fdbk_ctrl_pkg::*;
();

	logic clk = 1'b0;
	logic rst_n;
	sample_t in_xy;
	logic iq;
	logic sync;
	sample_t set_i;
	sample_t set_q;
	gain_t kp;
	gain_t ki;
	sample_t lim_hi;
	sample_t lim_lo;
	cshift_t coarse_scale;
	logic ll_en;
	sample_t out_xy;

	int error_count = 0;
	int check_count = 0;
	int seed = 48402;
	logic pending = 1'b0;
	logic table_ready = 1'b0;

	`include "fdbk_tb_model.svh"

	fdbk_core fdbk_core_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_xy        (in_xy),
		.iq           (iq),
		.sync         (sync),
		.set_i        (set_i),
		.set_q        (set_q),
		.kp           (kp),
		.ki           (ki),
		.lim_hi       (lim_hi),
		.lim_lo       (lim_lo),
		.coarse_scale (coarse_scale),
		.ll_en        (ll_en),
		.out_xy       (out_xy)
	);

	// 20 ns period
	always #10 clk = ~clk;

	task automatic apply_row(input int r);
		set_i = sample_t'(stim_rows[r].set_i);
		set_q = sample_t'(stim_rows[r].set_q);
		kp = gain_t'(stim_rows[r].kp);
		ki = gain_t'(stim_rows[r].ki);
		lim_hi = sample_t'(stim_rows[r].lim_hi);
		lim_lo = sample_t'(stim_rows[r].lim_lo);
		coarse_scale = cshift_t'(stim_rows[r].cscale);
		ll_en = stim_rows[r].ll_en;
	endtask

	task automatic check_out(input string what, input longint expected);
		sample_t exp_w;
		exp_w = sample_t'(expected);
		check_count++;
		assert (out_xy === exp_w) else begin
			error_count++;
			$display("[FAIL] out_xy (%s, row %0d): got %h, expected %h",
				what, pend_row, out_xy, exp_w);
		end
	endtask

	// Streams one frame, checking the previous frame's drive on the way
	task automatic run_frame(input int r, input int len, input bit junk, input bit update);
		longint val;
		for (int s = 0; s < len; s++) begin
			@(posedge clk);
			#2;
			if (junk) begin
				// Large words that would show if the partial frame leaked
				val = (s % 2 == 0) ? 100000 : -100000;
			end else begin
				val = (s % 2 == 0) ? stim_rows[r].in_i : stim_rows[r].in_q;
				if (stim_rows[r].noise) begin
					val = val + ($random(seed) % 8);
				end
			end
			words[s] = val;
			in_xy = sample_t'(val);
			iq = (s % 2 == 0);
			sync = (s == 0);
			// Settings change only once the previous frame has been checked
			if (s == 5) begin
				apply_row(r);
			end
			if (pending && s == 3) begin
				@(negedge clk);
				check_out("4 cycles after Q3", expect_first());
			end
			if (pending && s == 4) begin
				@(negedge clk);
				check_out("5 cycles after Q3", expect_second());
				pending = 1'b0;
			end
		end
		if (update) begin
			model_frame(r);
			pending = 1'b1;
			pend_row = r;
		end
	endtask

	initial begin
		fill_table();
		table_ready = 1'b1;
		rst_n = 1'b0;
		in_xy = '0;
		iq = 1'b0;
		sync = 1'b0;
		apply_row(0);
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		// Nothing driven before the first drive update
		repeat (4) begin
			@(negedge clk);
			check_out("idle after reset", 0);
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			// Short frame, then a sync where the decimator expects I3
			if (stim_rows[r].resync) begin
				run_frame(r, 6, 1'b1, 1'b0);
			end
			for (int f = 0; f < stim_rows[r].frames; f++) begin
				run_frame(r, 8, 1'b0, 1'b1);
			end
		end
		// One more frame flushes the last check
		run_frame(NUM_ROWS - 1, 8, 1'b0, 1'b0);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		int total;
		total = 0;
		wait (table_ready);
		for (int r = 0; r < NUM_ROWS; r++) begin
			total = total + stim_rows[r].frames;
		end
		repeat (total * 8 + 200) @(posedge clk);
		$display("Timeout: stimulus did not complete within %0d cycles", total * 8 + 200);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
